//--- Bender.yml
package:
  name: scurve

sources:
  - hw/scurve_pkg.sv
  - hw/scurve_input_sync.sv
  - hw/scurve_channel.sv
  - hw/scurve_scan_ctrl.sv
  - hw/scurve_result_out.sv
  - hw/scurve_top.sv
  - target: test
    files:
      - verif/tb_scurve.sv

//--- flist.f
hw/scurve_pkg.sv
hw/scurve_input_sync.sv
hw/scurve_channel.sv
hw/scurve_scan_ctrl.sv
hw/scurve_result_out.sv
hw/scurve_top.sv
verif/tb_scurve.sv

//--- hw/scurve_channel.sv
module scurve_channel import scurve_pkg::*; #(
  parameter int CH_SEL = 0
) (
  input  logic      Clk,
  input  logic      reset_n,
  input  sync_evt_t evt,
  input  cnt_t      cpt_max,
  input  logic      clear,
  input  logic      run,
  output logic      done,
  output cnt_t      pulse_cnt,
  output cnt_t      trig_cnt
);

  // Window open for counting
  logic enable;
  // Trigger already taken in this inject pulse
  logic armed_off;
  // Inject pulse whose rise was counted
  logic pulse_open;
  // Trigger accepted this cycle
  logic trig_hit;

  //////////////////////////////////////////////////////////////////////
  // Gating
  //////////////////////////////////////////////////////////////////////

  assign enable = run & ~done;

  // A pulse already high when the window opens carries no trigger
  assign pulse_open = evt.inj_rise | (pulse_cnt != '0);

  // Trigger counts only inside inject high, once per pulse
  assign trig_hit = enable & evt.inj_level & evt.trig_fall[CH_SEL]
                  & ~armed_off & pulse_open;

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  // Inject rising edges
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      pulse_cnt <= '0;
    end else if (clear) begin
      pulse_cnt <= '0;
    end else if (enable && evt.inj_rise) begin
      pulse_cnt <= pulse_cnt + 1'b1;
    end
  end

  // Trigger falling edges
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trig_cnt <= '0;
    end else if (clear) begin
      trig_cnt <= '0;
    end else if (trig_hit) begin
      trig_cnt <= trig_cnt + 1'b1;
    end
  end

  // One-per-pulse latch, released when inject goes low
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      armed_off <= 1'b0;
    end else if (clear || !evt.inj_level) begin
      armed_off <= 1'b0;
    end else if (trig_hit) begin
      armed_off <= 1'b1;
    end
  end

  // Window closes on the inject fall after the last counted pulse
  // so its trigger still lands
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      done <= 1'b0;
    end else if (clear) begin
      done <= 1'b0;
    end else if (enable && evt.inj_fall && pulse_cnt >= cpt_max) begin
      done <= 1'b1;
    end
  end

  // No more triggers than counted inject pulses
  a_trig_le_pulse: assert property (@(posedge Clk) disable iff (!reset_n)
    trig_cnt <= pulse_cnt);

  // Closed window freezes both counts until the next clear
  a_hold_when_done: assert property (@(posedge Clk) disable iff (!reset_n)
    done && !clear |=> $stable(pulse_cnt) && $stable(trig_cnt));

endmodule

//--- hw/scurve_input_sync.sv
module scurve_input_sync import scurve_pkg::*; (
  input  logic              Clk,
  input  logic              reset_n,
  input  logic              inject,
  input  logic [NUM_CH-1:0] trigger,
  output sync_evt_t         evt
);

  // Inject path with two sync stages and one history stage
  logic inj_s1;
  logic inj_s2;
  logic inj_d;
  // Trigger paths with the same structure per channel
  logic [NUM_CH-1:0] trig_s1;
  logic [NUM_CH-1:0] trig_s2;
  logic [NUM_CH-1:0] trig_d;

  // Inject idles low
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      inj_s1 <= 1'b0;
      inj_s2 <= 1'b0;
      inj_d  <= 1'b0;
    end else begin
      inj_s1 <= inject;
      inj_s2 <= inj_s1;
      inj_d  <= inj_s2;
    end
  end

  // Discriminator outputs idle high
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trig_s1 <= '1;
      trig_s2 <= '1;
      trig_d  <= '1;
    end else begin
      trig_s1 <= trigger;
      trig_s2 <= trig_s1;
      trig_d  <= trig_s2;
    end
  end

  // Levels and edges line up two cycles behind the pins
  always_comb begin
    evt.inj_level  = inj_s2;
    evt.inj_rise   = inj_s2 & ~inj_d;
    evt.inj_fall   = ~inj_s2 & inj_d;
    evt.trig_level = trig_s2;
    // Falling edge only as a hit pulls the line low
    evt.trig_fall  = ~trig_s2 & trig_d;
  end

  // Inject edges never meet and come at least two cycles apart
  a_inj_edges_excl: assert property (@(posedge Clk) disable iff (!reset_n)
    (evt.inj_rise || evt.inj_fall) |=> !(evt.inj_rise || evt.inj_fall));

endmodule

//--- hw/scurve_pkg.sv
package scurve_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes and timing
  //////////////////////////////////////////////////////////////////////

  // Trigger channels per chip
  localparam int NUM_CH = 4;
  // Counter and DAC code widths
  localparam int CNT_W = 16;
  localparam int DAC_W = 10;
  // Channel index width
  localparam int CH_W = 2;
  // DAC settling wait, never below NUM_CH
  localparam int SETTLE_CYC = 8;
  // Width of the settle and drain counter
  localparam int SETTLE_W = $clog2(SETTLE_CYC + 1);

  //////////////////////////////////////////////////////////////////////
  // Shared types
  //////////////////////////////////////////////////////////////////////

  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [DAC_W-1:0] dac_t;

  // Scan range and window length
  typedef struct packed {
    dac_t start_code;
    dac_t stop_code;
    dac_t step;
    cnt_t cpt_max;
  } scan_cfg_t;

  // Inject and trigger events after synchronization
  typedef struct packed {
    logic              inj_level;
    logic              inj_rise;
    logic              inj_fall;
    logic [NUM_CH-1:0] trig_level;
    logic [NUM_CH-1:0] trig_fall;
  } sync_evt_t;

  // One record per channel and DAC step
  typedef struct packed {
    dac_t            dac_code;
    logic [CH_W-1:0] channel;
    cnt_t            pulse_cnt;
    cnt_t            trig_cnt;
  } result_t;

endpackage

//--- hw/scurve_result_out.sv
module scurve_result_out import scurve_pkg::*; (
  input  logic              Clk,
  input  logic              reset_n,
  input  logic              capture,
  input  dac_t              dac_code,
  input  cnt_t [NUM_CH-1:0] pulse_cnt,
  input  cnt_t [NUM_CH-1:0] trig_cnt,
  output result_t           result,
  output logic              result_valid
);

  // Snapshot of one step
  dac_t              code_q;
  cnt_t [NUM_CH-1:0] pulse_q;
  cnt_t [NUM_CH-1:0] trig_q;
  // Emission control
  logic              emitting;
  logic [CH_W-1:0]   ch_idx;

  //////////////////////////////////////////////////////////////////////
  // Snapshot
  //////////////////////////////////////////////////////////////////////

  // Frees the channels for the next step right away
  always_ff @(posedge Clk) begin
    if (capture) begin
      code_q  <= dac_code;
      pulse_q <= pulse_cnt;
      trig_q  <= trig_cnt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Channel walk
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      emitting <= 1'b0;
      ch_idx   <= '0;
    end else if (capture) begin
      emitting <= 1'b1;
      ch_idx   <= '0;
    end else if (emitting) begin
      ch_idx <= ch_idx + 1'b1;
      // Last channel out
      if (ch_idx == CH_W'(NUM_CH - 1)) begin
        emitting <= 1'b0;
      end
    end
  end

  // Record mux, one channel per cycle
  always_comb begin
    result.dac_code  = code_q;
    result.channel   = ch_idx;
    result.pulse_cnt = pulse_q[ch_idx];
    result.trig_cnt  = trig_q[ch_idx];
  end

  assign result_valid = emitting;

  // Each capture yields exactly NUM_CH records before the next one
  a_no_overlap: assert property (@(posedge Clk) disable iff (!reset_n)
    capture |-> !emitting ##1 emitting [*NUM_CH] ##1 !emitting);

endmodule

//--- hw/scurve_scan_ctrl.sv
module scurve_scan_ctrl import scurve_pkg::*; (
  input  logic              Clk,
  input  logic              reset_n,
  input  scan_cfg_t         cfg,
  input  logic              start,
  input  logic [NUM_CH-1:0] ch_done,
  output dac_t              dac_code,
  output logic              clear,
  output logic              run,
  output logic              capture,
  output logic              busy,
  output logic              scan_done
);

  typedef enum logic [2:0] {
    IDLE,
    SETTLE,
    CLEAR,
    COUNT,
    CAPTURE,
    NEXT
  } state_t;

  state_t state;
  // Settle wait also drains the last records
  logic [SETTLE_W-1:0] wait_cnt;
  // One extra bit catches the wrap past the DAC range
  logic [DAC_W:0] next_code;
  logic last_step;

  //////////////////////////////////////////////////////////////////////
  // Code stepping
  //////////////////////////////////////////////////////////////////////

  assign next_code = {1'b0, dac_code} + {1'b0, cfg.step};
  assign last_step = next_code > {1'b0, cfg.stop_code};

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= IDLE;
      wait_cnt  <= '0;
      dac_code  <= '0;
      scan_done <= 1'b0;
    end else begin
      scan_done <= 1'b0;
      case (state)
        // Start only taken here and ignored while busy
        IDLE: begin
          if (start) begin
            dac_code <= cfg.start_code;
            wait_cnt <= '0;
            state    <= SETTLE;
          end
        end
        // DAC settling
        SETTLE: begin
          if (wait_cnt == SETTLE_W'(SETTLE_CYC - 1)) begin
            state <= CLEAR;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        CLEAR: state <= COUNT;
        // Wait for every channel window to close
        COUNT: begin
          if (&ch_done) begin
            state <= CAPTURE;
          end
        end
        CAPTURE: begin
          wait_cnt <= '0;
          state    <= NEXT;
        end
        // Advance or hold until the last records are out
        NEXT: begin
          if (!last_step) begin
            dac_code <= next_code[DAC_W-1:0];
            wait_cnt <= '0;
            state    <= SETTLE;
          end else if (wait_cnt == SETTLE_W'(NUM_CH - 1)) begin
            scan_done <= 1'b1;
            state     <= IDLE;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Decoded strobes and levels
  assign clear   = (state == CLEAR);
  assign run     = (state == COUNT);
  assign capture = (state == CAPTURE);
  assign busy    = (state != IDLE);

  // Every window still closed when its counts are captured
  a_capture_after_done: assert property (@(posedge Clk) disable iff (!reset_n)
    capture |-> &ch_done);

endmodule

//--- hw/scurve_top.sv
module scurve_top import scurve_pkg::*; (
  input  logic              Clk,
  input  logic              reset_n,
  // Asynchronous chip lines
  input  logic              inject,
  input  logic [NUM_CH-1:0] trigger,
  // Scan control
  input  scan_cfg_t         cfg,
  input  logic              start,
  output dac_t              dac_code,
  output logic              busy,
  output logic              scan_done,
  // Result stream
  output result_t           result,
  output logic              result_valid
);

  // Synchronized events
  sync_evt_t         evt;
  // Controller to channels
  logic              clear;
  logic              run;
  logic              capture;
  // Channels back
  logic [NUM_CH-1:0] ch_done;
  cnt_t [NUM_CH-1:0] pulse_cnt;
  cnt_t [NUM_CH-1:0] trig_cnt;

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  scurve_input_sync sync0 (
    .Clk     (Clk),
    .reset_n (reset_n),
    .inject  (inject),
    .trigger (trigger),
    .evt     (evt)
  );

  // One counter pair per trigger line
  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    scurve_channel #(
      .CH_SEL (i)
    ) ch0 (
      .Clk       (Clk),
      .reset_n   (reset_n),
      .evt       (evt),
      .cpt_max   (cfg.cpt_max),
      .clear     (clear),
      .run       (run),
      .done      (ch_done[i]),
      .pulse_cnt (pulse_cnt[i]),
      .trig_cnt  (trig_cnt[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Scan control and output
  //////////////////////////////////////////////////////////////////////

  scurve_scan_ctrl ctrl0 (
    .Clk       (Clk),
    .reset_n   (reset_n),
    .cfg       (cfg),
    .start     (start),
    .ch_done   (ch_done),
    .dac_code  (dac_code),
    .clear     (clear),
    .run       (run),
    .capture   (capture),
    .busy      (busy),
    .scan_done (scan_done)
  );

  // Latches on capture while the next step settles
  scurve_result_out out0 (
    .Clk          (Clk),
    .reset_n      (reset_n),
    .capture      (capture),
    .dac_code     (dac_code),
    .pulse_cnt    (pulse_cnt),
    .trig_cnt     (trig_cnt),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

//--- verif/tb_scurve.sv
module tb_scurve import scurve_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PAT_LEN = 256;
  localparam int INJ_PERIOD = 12;

  // DUT ports
  logic              Clk;
  logic              reset_n;
  logic              inject;
  logic [NUM_CH-1:0] trigger;
  scan_cfg_t         cfg;
  logic              start;
  dac_t              dac_code;
  logic              busy;
  logic              scan_done;
  result_t           result;
  logic              result_valid;

  // Channel model
  int unsigned       thr [NUM_CH];
  logic [NUM_CH-1:0] dbl_pat [PAT_LEN];
  logic [NUM_CH-1:0] noise_pat [PAT_LEN];
  logic [NUM_CH-1:0] trig_next;
  logic              fire;
  int                phase;
  int                pulse_idx;

  // Scoreboard state
  dac_t    exp_code;
  int      exp_ch;
  int      rec_cnt;
  int      done_cnt;
  int      recs_at_done;
  result_t exp_rec;
  int      err_cnt;
  int      pass_tests;
  int      fail_tests;

  // Watchdog
  logic  watch_on;
  int    watch_cnt;
  int    watch_limit;
  string cur_test;
  int    seed_val;

  scurve_top dut0 (
    .Clk          (Clk),
    .reset_n      (reset_n),
    .inject       (inject),
    .trigger      (trigger),
    .cfg          (cfg),
    .start        (start),
    .dac_code     (dac_code),
    .busy         (busy),
    .scan_done    (scan_done),
    .result       (result),
    .result_valid (result_valid)
  );

  initial Clk = 1'b0;
  always #2 Clk = ~Clk;

  //////////////////////////////////////////////////////////////////////
  // Reference and checking
  //////////////////////////////////////////////////////////////////////

  // Ideal S-curve where every window ends after exactly cpt_max pulses
  function automatic result_t expect_record(input dac_t code, input int ch,
                                            input cnt_t cpt, input int unsigned thr_c);
    result_t r;
    r.dac_code  = code;
    r.channel   = CH_W'(ch);
    r.pulse_cnt = cpt;
    r.trig_cnt  = (int'(code) < thr_c) ? cpt : '0;
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got,
                       input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Sampled on the falling edge where outputs are settled
  always @(negedge Clk) begin
    if (reset_n && result_valid) begin
      exp_rec = expect_record(exp_code, exp_ch, cfg.cpt_max, thr[exp_ch]);
      check("result.dac_code", result.dac_code, exp_rec.dac_code);
      check("result.channel", result.channel, exp_rec.channel);
      check("result.pulse_cnt", result.pulse_cnt, exp_rec.pulse_cnt);
      check("result.trig_cnt", result.trig_cnt, exp_rec.trig_cnt);
      rec_cnt++;
      // Channel order within a code, then next code
      if (exp_ch == NUM_CH - 1) begin
        exp_ch   = 0;
        exp_code = exp_code + cfg.step;
      end else begin
        exp_ch++;
      end
    end
    if (reset_n && scan_done) begin
      done_cnt++;
      recs_at_done = rec_cnt;
      check("busy", busy, 1'b0);
    end
  end

  // Ends a stuck scan
  always @(posedge Clk) begin
    if (watch_on) begin
      watch_cnt++;
      if (watch_cnt > watch_limit) begin
        $display("Timeout in %s: scan_done never came within %0d cycles",
                 cur_test, watch_limit);
        $display("Test FAILED");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Inject train and trigger model
  //////////////////////////////////////////////////////////////////////

  // Inject high 6 cycles and low 6
  // Hits at phases 1 and 4 and noise at phase 8
  always @(negedge Clk) begin
    if (!reset_n) begin
      phase     = 0;
      pulse_idx = 0;
      inject    <= 1'b0;
      trigger   <= '1;
    end else begin
      for (int c = 0; c < NUM_CH; c++) begin
        fire = int'(dac_code) < thr[c];
        case (phase)
          1, 2:    trig_next[c] = !fire;
          // Second hit in the same pulse
          4:       trig_next[c] = !(fire && dbl_pat[pulse_idx][c]);
          // Noise while inject is low
          8:       trig_next[c] = !noise_pat[pulse_idx][c];
          default: trig_next[c] = 1'b1;
        endcase
      end
      inject  <= (phase < INJ_PERIOD / 2);
      trigger <= trig_next;
      if (phase == INJ_PERIOD - 1) begin
        phase     = 0;
        pulse_idx = (pulse_idx + 1) % PAT_LEN;
      end else begin
        phase++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("%s: passed", name);
      pass_tests++;
    end else begin
      $display("%s: failed with %0d errors", name, err_cnt - errs_before);
      fail_tests++;
    end
  endtask

  // Outputs quiet before any start
  task automatic idle_check();
    int errs;
    errs = err_cnt;
    repeat (20) begin
      @(negedge Clk);
      check("busy", busy, 1'b0);
      check("scan_done", scan_done, 1'b0);
      check("result_valid", result_valid, 1'b0);
      check("dac_code", dac_code, '0);
    end
    report_test("idle_after_reset", errs);
  endtask

  task automatic run_scan(input string name, input scan_cfg_t c,
                          input int unsigned thr_lo, input int unsigned thr_span);
    int errs;
    int steps;
    errs = err_cnt;
    steps = (int'(c.stop_code) - int'(c.start_code)) / int'(c.step) + 1;
    for (int i = 0; i < NUM_CH; i++) begin
      thr[i] = thr_lo + $urandom_range(thr_span, 0);
    end
    exp_code     = c.start_code;
    exp_ch       = 0;
    rec_cnt      = 0;
    done_cnt     = 0;
    recs_at_done = -1;
    // Worst case per step is settle plus cpt_max + 2 inject periods
    cur_test    = name;
    watch_cnt   = 0;
    watch_limit = steps * ((int'(c.cpt_max) + 2) * INJ_PERIOD + 2 * SETTLE_CYC) + 100;
    watch_on    = 1'b1;
    @(negedge Clk);
    cfg   = c;
    start = 1'b1;
    @(negedge Clk);
    start = 1'b0;
    while (!busy) @(negedge Clk);
    // Restart attempt once the first step is out and the code has moved on
    while (rec_cnt < NUM_CH) @(negedge Clk);
    check("busy", busy, 1'b1);
    start = 1'b1;
    @(negedge Clk);
    start = 1'b0;
    while (done_cnt == 0) @(negedge Clk);
    watch_on = 1'b0;
    // Late records or a second done would show up here
    repeat (3 * SETTLE_CYC) @(negedge Clk);
    check("record count", rec_cnt, NUM_CH * steps);
    check("records before scan_done", recs_at_done, NUM_CH * steps);
    check("scan_done count", done_cnt, 1);
    check("busy", busy, 1'b0);
    report_test(name, errs);
  endtask

  initial begin
    scan_cfg_t cfg_a;
    scan_cfg_t cfg_b;
    inject      = 1'b0;
    trigger     = '1;
    cfg         = '0;
    start       = 1'b0;
    reset_n     = 1'b0;
    watch_on    = 1'b0;
    watch_cnt   = 0;
    watch_limit = 0;
    err_cnt     = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    rec_cnt     = 0;
    done_cnt    = 0;
    exp_code    = '0;
    exp_ch      = 0;
    for (int i = 0; i < NUM_CH; i++) begin
      thr[i] = 0;
    end
    seed_val = $urandom(32'h61d4_8698);
    // Double hits and noise per inject pulse
    for (int i = 0; i < PAT_LEN; i++) begin
      dbl_pat[i]   = NUM_CH'($urandom);
      noise_pat[i] = NUM_CH'($urandom);
    end
    repeat (2) @(negedge Clk);
    reset_n = 1'b1;

    idle_check();

    // Stop off the step grid so the last code is 40
    cfg_a.start_code = 10'd0;
    cfg_a.stop_code  = 10'd44;
    cfg_a.step       = 10'd8;
    cfg_a.cpt_max    = 16'd3;
    run_scan("scan_wide", cfg_a, 1, 47);

    // Shortest window
    cfg_b.start_code = 10'd100;
    cfg_b.stop_code  = 10'd130;
    cfg_b.step       = 10'd10;
    cfg_b.cpt_max    = 16'd1;
    run_scan("scan_single_pulse", cfg_b, 95, 45);

    $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_cnt);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
